//--- filelist.f
+incdir+.
mxu_pkg.sv
matrix_buffer.sv
skew_feeder.sv
systolic_pe.sv
systolic_array.sv
mxu_sequencer.sv
mxu_apb_regs.sv
mxu_top.sv
tb_mxu.sv

//--- matrix_buffer.sv
`include "mxu_cfg.svh"

module matrix_buffer #(
    parameter type word_t = mxu_pkg::elem_t
) (
    input  logic          sys_clock,
    input  logic          sys_reset,
    input  logic          wr_en,
    input  mxu_pkg::idx_t wr_index,
    input  word_t         wr_data,
    input  mxu_pkg::idx_t rd_index,
    output word_t         rd_data,
    output word_t         contents [`MXU_N*`MXU_N]
);

    localparam int DEPTH = `MXU_N * `MXU_N;

    // Row-major storage, element (i,j) at i*N + j
    word_t mem [DEPTH];

    // Single write port
    always_ff @(posedge sys_clock or posedge sys_reset) begin
        if (sys_reset) begin
            mem <= '{default: '0};
        end else if (wr_en) begin
            mem[wr_index] <= wr_data;
        end
    end

    // Random read port, same cycle
    assign rd_data = mem[rd_index];

    // Parallel view for the array feeder
    always_comb begin
        for (int k = 0; k < DEPTH; k++) begin
            contents[k] = mem[k];
        end
    end

endmodule

//--- mxu_apb_regs.sv
`include "mxu_cfg.svh"

module mxu_apb_regs (
    input  logic                sys_clock,
    input  logic                sys_reset,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  mxu_pkg::apb_addr_t  paddr,
    input  mxu_pkg::apb_data_t  pwdata,
    output mxu_pkg::apb_data_t  prdata,
    output logic                pready,
    output logic                pslverr,
    input  logic                busy,
    input  logic                done,
    output logic                start,
    output logic                a_wr_en,
    output logic                b_wr_en,
    output mxu_pkg::idx_t       wr_index,
    output mxu_pkg::idx_t       rd_index,
    output mxu_pkg::elem_t      wr_elem,
    input  mxu_pkg::elem_t      a_rd_data,
    input  mxu_pkg::elem_t      b_rd_data,
    input  mxu_pkg::acc_t       c_rd_data
);
    import mxu_pkg::*;

    localparam int DEPTH = `MXU_N * `MXU_N;

    logic      wr_access;
    logic      rd_access;
    logic      is_ctrl;
    logic      is_stat;
    logic      in_a;
    logic      in_b;
    logic      in_c;
    logic      mapped;
    logic      wr_bad;
    logic      done_q;
    apb_addr_t offset;
    apb_data_t status_word;

    // Address falls inside an N*N word window starting at base
    function automatic logic in_region(apb_addr_t addr, apb_addr_t base);
        apb_addr_t rel;
        rel = addr - base;
        return int'(rel) < DEPTH;
    endfunction

    // ------------------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------------------
    assign wr_access = psel && penable && pwrite;
    assign rd_access = psel && penable && !pwrite;

    assign is_ctrl = (paddr == apb_addr_t'(`MXU_REG_CONTROL));
    assign is_stat = (paddr == apb_addr_t'(`MXU_REG_STATUS));
    assign in_a    = in_region(paddr, apb_addr_t'(`MXU_BASE_A));
    assign in_b    = in_region(paddr, apb_addr_t'(`MXU_BASE_B));
    assign in_c    = in_region(paddr, apb_addr_t'(`MXU_BASE_C));
    assign mapped  = is_ctrl || is_stat || in_a || in_b || in_c;

    // Element offset inside whichever matrix window is hit
    always_comb begin
        offset = '0;
        if (in_a) begin
            offset = paddr - apb_addr_t'(`MXU_BASE_A);
        end else if (in_b) begin
            offset = paddr - apb_addr_t'(`MXU_BASE_B);
        end else if (in_c) begin
            offset = paddr - apb_addr_t'(`MXU_BASE_C);
        end
    end

    assign wr_index = idx_t'(offset);
    assign rd_index = idx_t'(offset);
    assign wr_elem  = elem_t'(pwdata);

    // Read-only regions, and operand buffers locked during a run
    assign wr_bad  = !mapped || is_stat || in_c || ((in_a || in_b) && busy);
    assign pslverr = (wr_access && wr_bad) || (rd_access && !mapped);
    assign pready  = 1'b1;

    assign a_wr_en = wr_access && in_a && !busy;
    assign b_wr_en = wr_access && in_b && !busy;

    // ------------------------------------------------------------------------
    // Control and status
    // ------------------------------------------------------------------------
    always_ff @(posedge sys_clock or posedge sys_reset) begin
        if (sys_reset) begin
            start  <= 1'b0;
            done_q <= 1'b0;
        end else begin
            start <= wr_access && is_ctrl && pwdata[0] && !busy;
            // New run request drops the sticky done flag
            if (wr_access && is_ctrl && pwdata[0] && !busy) begin
                done_q <= 1'b0;
            end else if (done) begin
                done_q <= 1'b1;
            end
        end
    end

    assign status_word = apb_data_t'({done_q, busy});

    // Read data mux, elements zero-extended to the bus width
    always_comb begin
        prdata = '0;
        if (rd_access) begin
            if (is_stat) begin
                prdata = status_word;
            end else if (in_a) begin
                prdata = apb_data_t'(a_rd_data);
            end else if (in_b) begin
                prdata = apb_data_t'(b_rd_data);
            end else if (in_c) begin
                prdata = apb_data_t'(c_rd_data);
            end
        end
    end

endmodule

//--- mxu_cfg.svh
`ifndef MXU_CFG_SVH
`define MXU_CFG_SVH

// Array and datapath sizes
`define MXU_N           4
`define MXU_ELEM_W      8
`define MXU_ACC_W       32

// APB port, word addressed
`define MXU_APB_ADDR_W  8
`define MXU_APB_DATA_W  32

// Register map
`define MXU_REG_CONTROL 8'h00
`define MXU_REG_STATUS  8'h01
`define MXU_BASE_A      8'h40
`define MXU_BASE_B      8'h80
`define MXU_BASE_C      8'hC0

// Zero-input cycles after the last feed step
`define MXU_DRAIN       `MXU_N

`endif

//--- mxu_pkg.sv
package mxu_pkg;

    `include "mxu_cfg.svh"

    // Operand element, unsigned
    typedef logic [`MXU_ELEM_W-1:0] elem_t;

    // Result accumulator, wraps modulo 2^ACC_W
    typedef logic [`MXU_ACC_W-1:0] acc_t;

    // Flat row-major index into an NxN matrix
    typedef logic [$clog2(`MXU_N*`MXU_N)-1:0] idx_t;

    // APB word address and data
    typedef logic [`MXU_APB_ADDR_W-1:0] apb_addr_t;
    typedef logic [`MXU_APB_DATA_W-1:0] apb_data_t;

    // Run sequencer states
    typedef enum logic [2:0] {
        IDLE,
        CLEAR,
        FEED,
        DRAIN,
        WRITEBACK,
        DONE
    } seq_state_e;

endpackage

//--- mxu_sequencer.sv
`include "mxu_cfg.svh"

module mxu_sequencer (
    input  logic          sys_clock,
    input  logic          sys_reset,
    input  logic          start,
    input  logic          feed_last,
    input  mxu_pkg::acc_t acc_data,
    output logic          busy,
    output logic          done,
    output logic          feed,
    output logic          clear,
    output logic          en,
    output mxu_pkg::idx_t acc_index,
    output logic          c_wr_en,
    output mxu_pkg::idx_t c_wr_index,
    output mxu_pkg::acc_t c_wr_data
);
    import mxu_pkg::*;

    localparam int   DRAIN_W = $clog2(`MXU_DRAIN + 1);
    localparam idx_t WB_LAST = idx_t'(`MXU_N * `MXU_N - 1);

    seq_state_e         state;
    seq_state_e         state_nxt;
    logic [DRAIN_W-1:0] drain_cnt;
    idx_t               wb_idx;

    // ------------------------------------------------------------------------
    // Next state
    // ------------------------------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:      if (start) state_nxt = CLEAR;
            CLEAR:     state_nxt = FEED;
            // Feeder flags its own final diagonal
            FEED:      if (feed_last) state_nxt = DRAIN;
            DRAIN:     if (drain_cnt == DRAIN_W'(`MXU_DRAIN - 1)) state_nxt = WRITEBACK;
            WRITEBACK: if (wb_idx == WB_LAST) state_nxt = DONE;
            DONE:      state_nxt = IDLE;
            default:   state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge sys_clock or posedge sys_reset) begin
        if (sys_reset) begin
            state     <= IDLE;
            drain_cnt <= '0;
            wb_idx    <= '0;
        end else begin
            state <= state_nxt;
            // Drain length counter
            if (state == DRAIN) begin
                drain_cnt <= drain_cnt + 1'b1;
            end else begin
                drain_cnt <= '0;
            end
            // One result word per writeback cycle
            if ((state == WRITEBACK) && (wb_idx != WB_LAST)) begin
                wb_idx <= wb_idx + 1'b1;
            end else begin
                wb_idx <= '0;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Outputs decoded from state
    // ------------------------------------------------------------------------
    // Busy drops in the same cycle the done pulse appears
    assign busy  = (state == CLEAR) || (state == FEED) ||
                   (state == DRAIN) || (state == WRITEBACK);
    assign done  = (state == DONE);
    assign clear = (state == CLEAR);
    assign feed  = (state == FEED);
    assign en    = (state == FEED) || (state == DRAIN);

    // Array read and C write share the index
    assign acc_index  = wb_idx;
    assign c_wr_en    = (state == WRITEBACK);
    assign c_wr_index = wb_idx;
    assign c_wr_data  = acc_data;

endmodule

//--- mxu_top.sv
`include "mxu_cfg.svh"

module mxu_top (
    input  logic               sys_clock,
    input  logic               sys_reset,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  mxu_pkg::apb_addr_t paddr,
    input  mxu_pkg::apb_data_t pwdata,
    output mxu_pkg::apb_data_t prdata,
    output logic               pready,
    output logic               pslverr
);
    import mxu_pkg::*;

    localparam int N = `MXU_N;

    // Control
    logic start;
    logic busy;
    logic done;
    logic feed;
    logic feed_last;
    logic clear;
    logic en;

    // Host buffer access
    logic  a_wr_en;
    logic  b_wr_en;
    idx_t  wr_index;
    idx_t  rd_index;
    elem_t wr_elem;
    elem_t a_rd_data;
    elem_t b_rd_data;
    acc_t  c_rd_data;

    // Datapath
    elem_t a_contents [N*N];
    elem_t b_contents [N*N];
    elem_t row_in [N];
    elem_t col_in [N];
    idx_t  acc_index;
    acc_t  acc_data;
    logic  c_wr_en;
    idx_t  c_wr_index;
    acc_t  c_wr_data;

    // ------------------------------------------------------------------------
    // Register port and buffers
    // ------------------------------------------------------------------------
    mxu_apb_regs u_regs (
        .sys_clock (sys_clock),
        .sys_reset (sys_reset),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .busy      (busy),
        .done      (done),
        .start     (start),
        .a_wr_en   (a_wr_en),
        .b_wr_en   (b_wr_en),
        .wr_index  (wr_index),
        .rd_index  (rd_index),
        .wr_elem   (wr_elem),
        .a_rd_data (a_rd_data),
        .b_rd_data (b_rd_data),
        .c_rd_data (c_rd_data)
    );

    matrix_buffer #(.word_t(elem_t)) u_buf_a (
        .sys_clock (sys_clock),
        .sys_reset (sys_reset),
        .wr_en     (a_wr_en),
        .wr_index  (wr_index),
        .wr_data   (wr_elem),
        .rd_index  (rd_index),
        .rd_data   (a_rd_data),
        .contents  (a_contents)
    );

    matrix_buffer #(.word_t(elem_t)) u_buf_b (
        .sys_clock (sys_clock),
        .sys_reset (sys_reset),
        .wr_en     (b_wr_en),
        .wr_index  (wr_index),
        .wr_data   (wr_elem),
        .rd_index  (rd_index),
        .rd_data   (b_rd_data),
        .contents  (b_contents)
    );

    // Results land here during writeback, host reads only
    matrix_buffer #(.word_t(acc_t)) u_buf_c (
        .sys_clock (sys_clock),
        .sys_reset (sys_reset),
        .wr_en     (c_wr_en),
        .wr_index  (c_wr_index),
        .wr_data   (c_wr_data),
        .rd_index  (rd_index),
        .rd_data   (c_rd_data),
        .contents  ()
    );

    // ------------------------------------------------------------------------
    // Compute path
    // ------------------------------------------------------------------------
    skew_feeder u_feeder (
        .sys_clock  (sys_clock),
        .sys_reset  (sys_reset),
        .feed       (feed),
        .a_contents (a_contents),
        .b_contents (b_contents),
        .row_in     (row_in),
        .col_in     (col_in),
        .feed_last  (feed_last)
    );

    systolic_array u_array (
        .sys_clock (sys_clock),
        .sys_reset (sys_reset),
        .clear     (clear),
        .en        (en),
        .row_in    (row_in),
        .col_in    (col_in),
        .rd_index  (acc_index),
        .rd_data   (acc_data)
    );

    mxu_sequencer u_seq (
        .sys_clock  (sys_clock),
        .sys_reset  (sys_reset),
        .start      (start),
        .feed_last  (feed_last),
        .acc_data   (acc_data),
        .busy       (busy),
        .done       (done),
        .feed       (feed),
        .clear      (clear),
        .en         (en),
        .acc_index  (acc_index),
        .c_wr_en    (c_wr_en),
        .c_wr_index (c_wr_index),
        .c_wr_data  (c_wr_data)
    );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the MXU testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -f filelist.f --top-module tb_mxu -o sim_mxu
./obj_dir/sim_mxu | tee "$LOG"

# The log decides the outcome
if grep -q "Simulation completed successfully" "$LOG"; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi

//--- skew_feeder.sv
`include "mxu_cfg.svh"

module skew_feeder (
    input  logic           sys_clock,
    input  logic           sys_reset,
    input  logic           feed,
    input  mxu_pkg::elem_t a_contents [`MXU_N*`MXU_N],
    input  mxu_pkg::elem_t b_contents [`MXU_N*`MXU_N],
    output mxu_pkg::elem_t row_in [`MXU_N],
    output mxu_pkg::elem_t col_in [`MXU_N],
    output logic           feed_last
);

    localparam int N         = `MXU_N;
    localparam int LAST_STEP = 3 * N - 3;
    localparam int STEP_W    = $clog2(LAST_STEP + 1);

    logic [STEP_W-1:0] step;

    // ------------------------------------------------------------------------
    // Step counter, 0 .. 3N-3 while feeding
    // ------------------------------------------------------------------------
    always_ff @(posedge sys_clock or posedge sys_reset) begin
        if (sys_reset) begin
            step <= '0;
        end else if (!feed || feed_last) begin
            step <= '0;
        end else begin
            step <= step + 1'b1;
        end
    end

    assign feed_last = feed && (step == STEP_W'(LAST_STEP));

    // ------------------------------------------------------------------------
    // Diagonal skew
    // ------------------------------------------------------------------------
    // Lane i lags by i steps
    // Row lane i gets A[i][k-i], column lane i gets B[k-i][i]
    for (genvar i = 0; i < N; i++) begin : g_lane
        always_comb begin : p_lane
            int k;
            k = int'(step) - i;
            row_in[i] = '0;
            col_in[i] = '0;
            // Outside the valid diagonal band both edges see zero
            if (feed && (k >= 0) && (k < N)) begin
                row_in[i] = a_contents[i * N + k];
                col_in[i] = b_contents[k * N + i];
            end
        end
    end

endmodule

//--- systolic_array.sv
`include "mxu_cfg.svh"

module systolic_array (
    input  logic           sys_clock,
    input  logic           sys_reset,
    input  logic           clear,
    input  logic           en,
    input  mxu_pkg::elem_t row_in [`MXU_N],
    input  mxu_pkg::elem_t col_in [`MXU_N],
    input  mxu_pkg::idx_t  rd_index,
    output mxu_pkg::acc_t  rd_data
);
    import mxu_pkg::*;

    localparam int N = `MXU_N;

    // A moves right along a row, B moves down a column
    elem_t a_link [N][N+1];
    elem_t b_link [N+1][N];
    acc_t  acc_q  [N*N];

    // Left and top edges
    for (genvar e = 0; e < N; e++) begin : g_edge
        assign a_link[e][0] = row_in[e];
        assign b_link[0][e] = col_in[e];
    end

    // Cell (i,j) ends up holding C[i][j]
    for (genvar i = 0; i < N; i++) begin : g_row
        for (genvar j = 0; j < N; j++) begin : g_col
            systolic_pe u_pe (
                .sys_clock (sys_clock),
                .sys_reset (sys_reset),
                .clear     (clear),
                .en        (en),
                .a_in      (a_link[i][j]),
                .b_in      (b_link[i][j]),
                .a_out     (a_link[i][j+1]),
                .b_out     (b_link[i+1][j]),
                .acc       (acc_q[i * N + j])
            );
        end
    end

    // Row-major result select
    assign rd_data = acc_q[rd_index];

endmodule

//--- systolic_pe.sv
module systolic_pe (
    input  logic           sys_clock,
    input  logic           sys_reset,
    input  logic           clear,
    input  logic           en,
    input  mxu_pkg::elem_t a_in,
    input  mxu_pkg::elem_t b_in,
    output mxu_pkg::elem_t a_out,
    output mxu_pkg::elem_t b_out,
    output mxu_pkg::acc_t  acc
);
    import mxu_pkg::*;

    acc_t product;

    // Full product widened to the accumulator
    assign product = acc_t'(a_in) * acc_t'(b_in);

    always_ff @(posedge sys_clock or posedge sys_reset) begin
        if (sys_reset) begin
            a_out <= '0;
            b_out <= '0;
            acc   <= '0;
        end else if (clear) begin
            // Start of a run, flush operands too
            a_out <= '0;
            b_out <= '0;
            acc   <= '0;
        end else if (en) begin
            a_out <= a_in;
            b_out <= b_in;
            acc   <= acc + product;
        end
    end

endmodule

//--- tb_mxu.sv
`include "mxu_cfg.svh"

module tb_mxu;
    timeunit 1ns;
    timeprecision 1ps;

    import mxu_pkg::*;

    localparam int N           = `MXU_N;
    localparam int RUN_CYCLES  = 1 + (3 * N - 2) + `MXU_DRAIN + N * N + 1;
    localparam int XFER_CYCLES = 3;
    // Three operand loads with readback, four C sweeps with polling, misc accesses
    localparam int XFERS       = 3 * 4 * N * N + 4 * (N * N + 12) + 40;
    localparam int MAX_CYCLES  = 16 * (XFERS * XFER_CYCLES + 4 * RUN_CYCLES);

    logic      sys_clock;
    logic      sys_reset;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;

    // Host-side copy of the operands
    elem_t     a_mat [N*N];
    elem_t     b_mat [N*N];

    // Pending compares, consumed by the compare process
    string     name_q [$];
    apb_data_t exp_q [$];
    apb_data_t act_q [$];
    event      check_ev;
    int        cycle_count = 0;

    mxu_top u_dut (
        .sys_clock (sys_clock),
        .sys_reset (sys_reset),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr)
    );

    // ------------------------------------------------------------------------
    // Clock and cycle limit
    // ------------------------------------------------------------------------
    initial begin : p_clock
        sys_clock = 1'b0;
        forever #20 sys_clock = ~sys_clock;
    end

    always @(posedge sys_clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the test sequence never finished", cycle_count);
            $display("Simulation failed");
            $fatal(1, "cycle limit reached");
        end
    end

    // ------------------------------------------------------------------------
    // Reference model and compare
    // ------------------------------------------------------------------------
    // C[i][j] as the sum of A[i][k]*B[k][j], wrapped to 32 bits
    function automatic acc_t ref_product(input int i, input int j);
        longint sum;
        sum = 0;
        for (int k = 0; k < N; k++) begin
            sum += longint'(a_mat[i * N + k]) * longint'(b_mat[k * N + j]);
        end
        return acc_t'(sum);
    endfunction

    task automatic expect_value(input string name, input apb_data_t expected,
                                input apb_data_t actual);
        name_q.push_back(name);
        exp_q.push_back(expected);
        act_q.push_back(actual);
        -> check_ev;
    endtask

    initial begin : p_compare
        string     name;
        apb_data_t expected;
        apb_data_t actual;
        forever begin
            @(check_ev);
            while (exp_q.size() != 0) begin
                name     = name_q.pop_front();
                expected = exp_q.pop_front();
                actual   = act_q.pop_front();
                assert (actual == expected) else begin
                    $display("ERR %s expected 0x%08h actual 0x%08h", name, expected, actual);
                    $display("Simulation failed");
                    $fatal(1, "value mismatch");
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // APB host
    // ------------------------------------------------------------------------
    // Setup, access, then release; outputs sampled mid access phase
    task automatic apb_transfer(input logic write, input apb_addr_t addr, input apb_data_t data,
                                output apb_data_t rdata, output logic err);
        @(posedge sys_clock);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge sys_clock);
        penable <= 1'b1;
        @(negedge sys_clock);
        rdata = prdata;
        err   = pslverr;
        expect_value("pready", 32'h1, apb_data_t'(pready));
        // Transfer completes on this edge
        @(posedge sys_clock);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic check_write(input string name, input int addr, input apb_data_t data,
                               input logic exp_err);
        apb_data_t rdata;
        logic      err;
        apb_transfer(1'b1, apb_addr_t'(addr), data, rdata, err);
        expect_value({name, " pslverr"}, apb_data_t'(exp_err), apb_data_t'(err));
    endtask

    task automatic check_read(input string name, input int addr, input apb_data_t expected,
                              input logic exp_err);
        apb_data_t rdata;
        logic      err;
        apb_transfer(1'b0, apb_addr_t'(addr), '0, rdata, err);
        expect_value(name, expected, rdata);
        expect_value({name, " pslverr"}, apb_data_t'(exp_err), apb_data_t'(err));
    endtask

    task automatic read_status(output apb_data_t status);
        logic err;
        apb_transfer(1'b0, `MXU_REG_STATUS, '0, status, err);
        expect_value("status pslverr", 32'h0, apb_data_t'(err));
    endtask

    // ------------------------------------------------------------------------
    // Test steps
    // ------------------------------------------------------------------------
    task automatic load_operands(input string name, input bit identity_a);
        for (int k = 0; k < N * N; k++) begin
            if (identity_a) begin
                a_mat[k] = (k / N == k % N) ? elem_t'(1) : elem_t'(0);
            end else begin
                a_mat[k] = elem_t'($urandom());
            end
            b_mat[k] = elem_t'($urandom());
        end
        for (int k = 0; k < N * N; k++) begin
            check_write({name, " write A"}, `MXU_BASE_A + k, apb_data_t'(a_mat[k]), 1'b0);
            check_write({name, " write B"}, `MXU_BASE_B + k, apb_data_t'(b_mat[k]), 1'b0);
        end
        // Readback, upper bus bits must be zero
        for (int k = 0; k < N * N; k++) begin
            check_read($sformatf("%s A[%0d]", name, k), `MXU_BASE_A + k,
                       apb_data_t'(a_mat[k]), 1'b0);
            check_read($sformatf("%s B[%0d]", name, k), `MXU_BASE_B + k,
                       apb_data_t'(b_mat[k]), 1'b0);
        end
    endtask

    task automatic start_run(input string name);
        apb_data_t status;
        check_write({name, " start"}, `MXU_REG_CONTROL, 32'h1, 1'b0);
        // Busy already up, old done bit gone
        read_status(status);
        expect_value({name, " status after start"}, 32'h1, status);
    endtask

    task automatic wait_done(input string name);
        apb_data_t status;
        status = '0;
        while (status[1] == 1'b0) begin
            read_status(status);
            // Busy and done never show together
            expect_value({name, " busy with done"}, 32'h0, apb_data_t'(status[0] & status[1]));
            expect_value({name, " status upper bits"}, 32'h0, status & 32'hFFFF_FFFC);
        end
        expect_value({name, " final status"}, 32'h2, status);
    endtask

    task automatic compare_results(input string name);
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                check_read($sformatf("%s C[%0d][%0d]", name, i, j), `MXU_BASE_C + i * N + j,
                           apb_data_t'(ref_product(i, j)), 1'b0);
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin : p_main
        int bad_addr [6];
        bad_addr = '{32'h02, 32'h3F, `MXU_BASE_A + N * N, `MXU_BASE_B + N * N,
                     `MXU_BASE_C + N * N, 32'hFF};
        void'($urandom(69192));
        sys_reset = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        repeat (8) @(posedge sys_clock);
        sys_reset <= 1'b0;

        // Idle after reset, C empty
        check_read("reset status", `MXU_REG_STATUS, '0, 1'b0);
        for (int k = 0; k < N * N; k++) begin
            check_read($sformatf("reset C[%0d]", k), `MXU_BASE_C + k, '0, 1'b0);
        end

        // Identity times B returns B
        load_operands("identity", 1'b1);
        start_run("identity");
        wait_done("identity");
        compare_results("identity");

        // Random product, operand writes refused while busy
        load_operands("random1", 1'b0);
        start_run("random1");
        check_write("random1 locked A", `MXU_BASE_A + N + 1, apb_data_t'(~a_mat[N + 1]), 1'b1);
        check_write("random1 locked B", `MXU_BASE_B + N * N - 1,
                    apb_data_t'(~b_mat[N * N - 1]), 1'b1);
        wait_done("random1");
        check_read("random1 A kept", `MXU_BASE_A + N + 1, apb_data_t'(a_mat[N + 1]), 1'b0);
        compare_results("random1");

        // Sticky done from the last run, cleared by the new start
        load_operands("random2", 1'b0);
        check_read("random2 status before start", `MXU_REG_STATUS, 32'h2, 1'b0);
        start_run("random2");
        wait_done("random2");
        compare_results("random2");

        // Refused accesses change nothing
        check_write("status write", `MXU_REG_STATUS, 32'h3, 1'b1);
        check_read("status after refused write", `MXU_REG_STATUS, 32'h2, 1'b0);
        check_write("C write", `MXU_BASE_C, 32'hDEAD_BEEF, 1'b1);
        check_read("C[0] after refused write", `MXU_BASE_C, apb_data_t'(ref_product(0, 0)), 1'b0);
        check_write("unmapped write", 32'h02, 32'h1, 1'b1);
        foreach (bad_addr[n]) begin
            check_read($sformatf("unmapped read 0x%02h", bad_addr[n]), bad_addr[n], '0, 1'b1);
        end

        // Let the compare process drain
        repeat (2) @(posedge sys_clock);
        if (exp_q.size() == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("%0d checks were never compared", exp_q.size());
            $display("Simulation failed");
            $fatal(1, "compare process stalled");
        end
    end

endmodule
